//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ex_stage
FILELIST  = compile.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJDIR)

//--- compile.f
hdl/ex_isa_pkg.sv
hdl/ex_pipe_pkg.sv
hdl/ex_issue_queue.sv
hdl/ex_alu.sv
hdl/ex_branch_unit.sv
hdl/ex_multiplier.sv
hdl/ex_stage.sv
sim/tb_ex_stage.sv

//--- hdl/ex_alu.sv
`timescale 1ns/1ns

module ex_alu (
	input  ex_pipe_pkg::ex_req_t    req_i,
	output ex_pipe_pkg::ex_result_t alu_o
);
	ex_isa_pkg::word_t reg1;
	ex_isa_pkg::word_t reg2;
	ex_isa_pkg::word_t op2;
	ex_isa_pkg::word_t addend;
	ex_isa_pkg::word_t sum;
	ex_isa_pkg::word_t logic_out;
	ex_isa_pkg::word_t shift_out;
	ex_isa_pkg::word_t arith_out;
	logic [4:0]        shamt;
	logic              imm_op;
	logic              signed_cmp;
	logic              sub_op;
	logic              addend_sign;
	logic              overflow;
	logic              ov_block;
	logic              reg1_eq;
	logic              reg1_lt;
	logic              trap;

	// leading zeros, or leading ones when ones is set
	function automatic logic [5:0] lead_count(input ex_isa_pkg::word_t w, input logic ones);
		logic [5:0] n;
		logic       found;
		n     = 6'd0;
		found = 1'b0;
		for (int i = ex_isa_pkg::reg_width - 1; i >= 0; i--) begin
			if (w[i] != ones)
				found = 1'b1;
			else if (!found)
				n = n + 6'd1;
		end
		return n;
	endfunction

	assign reg1  = req_i.reg1;
	assign reg2  = req_i.reg2;
	assign shamt = reg1[4:0];

	assign imm_op = req_i.aluop inside {ex_isa_pkg::exe_addi_op, ex_isa_pkg::exe_addiu_op,
		ex_isa_pkg::exe_slti_op, ex_isa_pkg::exe_sltiu_op, ex_isa_pkg::exe_teqi_op,
		ex_isa_pkg::exe_tgei_op, ex_isa_pkg::exe_tgeiu_op, ex_isa_pkg::exe_tlti_op,
		ex_isa_pkg::exe_tltiu_op, ex_isa_pkg::exe_tnei_op};
	assign signed_cmp = req_i.aluop inside {ex_isa_pkg::exe_slt_op, ex_isa_pkg::exe_slti_op,
		ex_isa_pkg::exe_tlt_op, ex_isa_pkg::exe_tlti_op, ex_isa_pkg::exe_tge_op,
		ex_isa_pkg::exe_tgei_op};
	assign sub_op = signed_cmp ||
		(req_i.aluop inside {ex_isa_pkg::exe_sub_op, ex_isa_pkg::exe_subu_op});

	// single adder shared by add, sub, slt and traps
	assign op2         = imm_op ? {{16{reg2[15]}}, reg2[15:0]} : reg2;
	assign addend      = sub_op ? ~op2 + 1'b1 : op2;
	assign sum         = reg1 + addend;
	assign addend_sign = sub_op ? ~op2[31] : op2[31];
	assign overflow    = (reg1[31] == addend_sign) && (sum[31] != reg1[31]);
	assign ov_block    = overflow && (req_i.aluop inside {ex_isa_pkg::exe_add_op,
		ex_isa_pkg::exe_addi_op, ex_isa_pkg::exe_sub_op});

	assign reg1_eq = (reg1 == op2);
	assign reg1_lt = signed_cmp ?
		((reg1[31] && !op2[31]) || ((reg1[31] == op2[31]) && sum[31])) : (reg1 < op2);

	assign trap =
		((req_i.aluop inside {ex_isa_pkg::exe_teq_op, ex_isa_pkg::exe_teqi_op}) && reg1_eq) ||
		((req_i.aluop inside {ex_isa_pkg::exe_tne_op, ex_isa_pkg::exe_tnei_op}) && !reg1_eq) ||
		((req_i.aluop inside {ex_isa_pkg::exe_tge_op, ex_isa_pkg::exe_tgei_op,
			ex_isa_pkg::exe_tgeu_op, ex_isa_pkg::exe_tgeiu_op}) && !reg1_lt) ||
		((req_i.aluop inside {ex_isa_pkg::exe_tlt_op, ex_isa_pkg::exe_tlti_op,
			ex_isa_pkg::exe_tltu_op, ex_isa_pkg::exe_tltiu_op}) && reg1_lt);

	always_comb begin
		case (req_i.aluop)
			ex_isa_pkg::exe_or_op,  ex_isa_pkg::exe_ori_op:  logic_out = reg1 | reg2;
			ex_isa_pkg::exe_and_op, ex_isa_pkg::exe_andi_op: logic_out = reg1 & reg2;
			ex_isa_pkg::exe_xor_op, ex_isa_pkg::exe_xori_op: logic_out = reg1 ^ reg2;
			ex_isa_pkg::exe_nor_op:                          logic_out = ~(reg1 | reg2);
			ex_isa_pkg::exe_lui_op:                          logic_out = {reg2[15:0], 16'h0};
			default:                                         logic_out = '0;
		endcase
	end

	always_comb begin
		case (req_i.aluop)
			ex_isa_pkg::exe_sll_op, ex_isa_pkg::exe_sllv_op: shift_out = reg2 << shamt;
			ex_isa_pkg::exe_srl_op, ex_isa_pkg::exe_srlv_op: shift_out = reg2 >> shamt;
			ex_isa_pkg::exe_sra_op, ex_isa_pkg::exe_srav_op: shift_out = $signed(reg2) >>> shamt;
			default:                                         shift_out = '0;
		endcase
	end

	always_comb begin
		case (req_i.aluop)
			ex_isa_pkg::exe_add_op, ex_isa_pkg::exe_addu_op, ex_isa_pkg::exe_addi_op,
			ex_isa_pkg::exe_addiu_op, ex_isa_pkg::exe_sub_op, ex_isa_pkg::exe_subu_op:
				arith_out = sum;
			ex_isa_pkg::exe_slt_op, ex_isa_pkg::exe_sltu_op, ex_isa_pkg::exe_slti_op,
			ex_isa_pkg::exe_sltiu_op:
				arith_out = ex_isa_pkg::word_t'(reg1_lt);
			ex_isa_pkg::exe_clz_op: arith_out = ex_isa_pkg::word_t'(lead_count(reg1, 1'b0));
			ex_isa_pkg::exe_clo_op: arith_out = ex_isa_pkg::word_t'(lead_count(reg1, 1'b1));
			default:                arith_out = '0;
		endcase
	end

	always_comb begin
		alu_o = '0;
		case (req_i.alusel)
			ex_isa_pkg::exe_res_logic:      alu_o.wdata = logic_out;
			ex_isa_pkg::exe_res_shift:      alu_o.wdata = shift_out;
			ex_isa_pkg::exe_res_arithmetic: alu_o.wdata = arith_out;
			default:                        alu_o.wdata = '0;
		endcase
		// nop, mul, jump and branch classes get their enable elsewhere
		alu_o.wreg_real = req_i.wreg && !ov_block && (req_i.alusel inside
			{ex_isa_pkg::exe_res_logic, ex_isa_pkg::exe_res_shift,
			ex_isa_pkg::exe_res_arithmetic});
		if (req_i.aluop == ex_isa_pkg::exe_eret_op)
			alu_o.excepttype = ex_isa_pkg::except_eret;
		else if (req_i.aluop == ex_isa_pkg::exe_syscall_op)
			alu_o.excepttype = ex_isa_pkg::except_syscall;
		else if (trap)
			alu_o.excepttype = ex_isa_pkg::except_tr;
	end

endmodule

//--- hdl/ex_branch_unit.sv
`timescale 1ns/1ns

module ex_branch_unit (
	input  ex_pipe_pkg::ex_req_t    req_i,
	output ex_pipe_pkg::ex_result_t br_o
);
	ex_isa_pkg::word_t link_addr;
	ex_isa_pkg::word_t jump_target;
	ex_isa_pkg::word_t branch_target;
	logic              taken;

	assign link_addr = req_i.pc + ex_isa_pkg::word_t'(4);

	// j/jal keep the region bits of the delay slot address
	assign jump_target = (req_i.aluop inside {ex_isa_pkg::exe_j_op, ex_isa_pkg::exe_jal_op}) ?
		{link_addr[31:28], req_i.reg1[25:0], 2'b00} : req_i.reg1;

	assign branch_target = req_i.pc + {{14{req_i.offset[15]}}, req_i.offset, 2'b00};

	always_comb begin
		case (req_i.aluop)
			ex_isa_pkg::exe_beq_op:  taken = (req_i.reg1 == req_i.reg2);
			ex_isa_pkg::exe_bne_op:  taken = (req_i.reg1 != req_i.reg2);
			ex_isa_pkg::exe_bgtz_op: taken = !req_i.reg1[31] && (req_i.reg1 != '0);
			ex_isa_pkg::exe_blez_op: taken = req_i.reg1[31] || (req_i.reg1 == '0);
			ex_isa_pkg::exe_bltz_op, ex_isa_pkg::exe_bltzal_op:
				taken = req_i.reg1[31];
			ex_isa_pkg::exe_bgez_op, ex_isa_pkg::exe_bgezal_op:
				taken = !req_i.reg1[31];
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		br_o = '0;
		if (req_i.alusel == ex_isa_pkg::exe_res_jump) begin
			br_o.wdata     = link_addr;
			br_o.wreg_real = req_i.wreg;
			br_o.redirect  = 1'b1;
			br_o.pc_target = jump_target;
		end else if (req_i.alusel == ex_isa_pkg::exe_res_branch) begin
			br_o.wdata     = link_addr;
			br_o.wreg_real = req_i.wreg;
			br_o.redirect  = taken;
			br_o.pc_target = branch_target;
		end
	end

endmodule

//--- hdl/ex_isa_pkg.sv
package ex_isa_pkg;

	localparam int reg_width      = 32;
	localparam int reg_addr_width = 5;

	typedef logic [reg_width-1:0] word_t;

	// operation codes as produced by decode
	typedef enum logic [7:0] {
		exe_nop_op     = 8'h00,
		// logic
		exe_and_op     = 8'h24, exe_or_op      = 8'h25, exe_xor_op     = 8'h26,
		exe_nor_op     = 8'h27, exe_andi_op    = 8'h59, exe_ori_op     = 8'h5a,
		exe_xori_op    = 8'h5b, exe_lui_op     = 8'h5c,
		// shifts
		exe_sll_op     = 8'h7c, exe_sllv_op    = 8'h04, exe_srl_op     = 8'h02,
		exe_srlv_op    = 8'h06, exe_sra_op     = 8'h03, exe_srav_op    = 8'h07,
		// arithmetic and compare
		exe_add_op     = 8'h20, exe_addu_op    = 8'h21, exe_sub_op     = 8'h22,
		exe_subu_op    = 8'h23, exe_addi_op    = 8'h55, exe_addiu_op   = 8'h56,
		exe_slt_op     = 8'h2a, exe_sltu_op    = 8'h2b, exe_slti_op    = 8'h57,
		exe_sltiu_op   = 8'h58, exe_clz_op     = 8'hb0, exe_clo_op     = 8'hb1,
		// multiply
		exe_mul_op     = 8'ha9, exe_mult_op    = 8'h18, exe_multu_op   = 8'h19,
		// jumps and branches
		exe_j_op       = 8'h4f, exe_jal_op     = 8'h50, exe_jalr_op    = 8'h09,
		exe_jr_op      = 8'h08, exe_beq_op     = 8'h51, exe_bne_op     = 8'h52,
		exe_bgtz_op    = 8'h54, exe_blez_op    = 8'h53, exe_bltz_op    = 8'h40,
		exe_bltzal_op  = 8'h4a, exe_bgez_op    = 8'h41, exe_bgezal_op  = 8'h4b,
		// traps
		exe_teq_op     = 8'h34, exe_teqi_op    = 8'h48, exe_tge_op     = 8'h30,
		exe_tgei_op    = 8'h44, exe_tgeu_op    = 8'h31, exe_tgeiu_op   = 8'h45,
		exe_tlt_op     = 8'h32, exe_tlti_op    = 8'h46, exe_tltu_op    = 8'h33,
		exe_tltiu_op   = 8'h47, exe_tne_op     = 8'h36, exe_tnei_op    = 8'h49,
		exe_syscall_op = 8'h0c, exe_eret_op    = 8'h6b
	} aluop_t;

	// result class, selects which unit owns wdata
	typedef enum logic [2:0] {
		exe_res_nop        = 3'd0,
		exe_res_logic      = 3'd1,
		exe_res_shift      = 3'd2,
		exe_res_arithmetic = 3'd3,
		exe_res_mul        = 3'd4,
		exe_res_jump       = 3'd5,
		exe_res_branch     = 3'd6
	} alusel_t;

	typedef enum logic [31:0] {
		except_none    = 32'h0000_0000,
		except_syscall = 32'h0000_0008,
		except_tr      = 32'h0000_000d,
		except_eret    = 32'h0000_000e
	} excepttype_t;

endpackage

//--- hdl/ex_issue_queue.sv
`timescale 1ns/1ns

module ex_issue_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                 clk,
	input  logic                 rst_i,
	input  ex_pipe_pkg::ex_req_t req_i,
	input  logic                 pop_i,
	output ex_pipe_pkg::ex_req_t head_o,
	output logic                 credit_o
);
	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	ex_pipe_pkg::ex_req_t mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             empty;
	logic             full;
	logic             push;
	logic             pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		next_ptr = (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(QUEUE_DEPTH));
	assign push  = req_i.valid && !full;
	assign pop   = pop_i && !empty;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= req_i;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			credit_o <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit back upstream per entry that leaves
			credit_o <= pop;
		end
	end

	always_comb begin
		head_o       = mem[rd_ptr];
		head_o.valid = !empty;
	end

	// upstream must hold a credit for every push
	a_no_push_full: assert property (@(posedge clk) disable iff (rst_i)
		req_i.valid |-> !full);

	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst_i)
		pop_i |-> !empty);

endmodule

//--- hdl/ex_multiplier.sv
`timescale 1ns/1ns

module ex_multiplier (
	input  logic                   clk,
	input  logic                   rst_i,
	input  ex_pipe_pkg::ex_req_t   req_i,
	output ex_pipe_pkg::mul_res_t  mul_o
);
	localparam int PROD_W = 2 * ex_isa_pkg::reg_width;

	ex_isa_pkg::word_t mag1;
	ex_isa_pkg::word_t mag2;
	logic [PROD_W-1:0] mag_prod;
	logic [PROD_W-1:0] prod;
	logic              signed_op;
	logic              is_mul;
	logic              is_hilo;

	assign signed_op = req_i.aluop inside {ex_isa_pkg::exe_mul_op, ex_isa_pkg::exe_mult_op};
	assign is_hilo   = req_i.valid &&
		(req_i.aluop inside {ex_isa_pkg::exe_mult_op, ex_isa_pkg::exe_multu_op});
	assign is_mul    = is_hilo || (req_i.valid && req_i.aluop == ex_isa_pkg::exe_mul_op);

	// multiply magnitudes, fix the sign afterwards
	// operands held at zero outside multiplies
	assign mag1     = !is_mul ? '0 :
		(signed_op && req_i.reg1[31]) ? ~req_i.reg1 + 1'b1 : req_i.reg1;
	assign mag2     = !is_mul ? '0 :
		(signed_op && req_i.reg2[31]) ? ~req_i.reg2 + 1'b1 : req_i.reg2;
	assign mag_prod = PROD_W'(mag1) * PROD_W'(mag2);
	assign prod     = (signed_op && (req_i.reg1[31] ^ req_i.reg2[31])) ?
		~mag_prod + 1'b1 : mag_prod;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			mul_o <= '0;
		end else begin
			mul_o.wreg    <= req_i.valid && req_i.wreg &&
				(req_i.aluop == ex_isa_pkg::exe_mul_op);
			mul_o.wreg_hi <= is_hilo;
			mul_o.wreg_lo <= is_hilo;
			mul_o.product <= prod;
		end
	end

	// zeroed operands must leave no product behind, sign fix included
	a_idle_product: assert property (@(posedge clk) disable iff (rst_i)
		!is_mul |=> (mul_o.product == '0));

endmodule

//--- hdl/ex_pipe_pkg.sv
package ex_pipe_pkg;

	// request as issued into the execute stage
	typedef struct packed {
		logic                                   valid;
		ex_isa_pkg::aluop_t                     aluop;
		ex_isa_pkg::alusel_t                    alusel;
		ex_isa_pkg::word_t                      reg1;
		ex_isa_pkg::word_t                      reg2;
		logic [ex_isa_pkg::reg_addr_width-1:0]  wd;
		logic                                   wreg;
		ex_isa_pkg::word_t                      pc;
		logic [15:0]                            offset;
	} ex_req_t;

	// wreg is the requested write, wreg_real the one allowed
	typedef struct packed {
		logic                                   valid;
		logic [ex_isa_pkg::reg_addr_width-1:0]  wd;
		logic                                   wreg;
		logic                                   wreg_real;
		ex_isa_pkg::word_t                      wdata;
		logic                                   wreg_hi;
		ex_isa_pkg::word_t                      wdata_hi;
		logic                                   wreg_lo;
		ex_isa_pkg::word_t                      wdata_lo;
		logic                                   redirect;
		ex_isa_pkg::word_t                      pc_target;
		ex_isa_pkg::excepttype_t                excepttype;
	} ex_result_t;

	typedef struct packed {
		logic                                   wreg;
		logic                                   wreg_hi;
		logic                                   wreg_lo;
		logic [2*ex_isa_pkg::reg_width-1:0]     product;
	} mul_res_t;

endpackage

//--- hdl/ex_stage.sv
`timescale 1ns/1ns

module ex_stage #(
	parameter int QUEUE_DEPTH = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic                    clk,
	input  logic                    rst_i,
	input  ex_pipe_pkg::ex_req_t    req_i,
	output logic                    credit_o,
	output ex_pipe_pkg::ex_result_t res_o,
	input  logic                    credit_i
);
	localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);

	ex_pipe_pkg::ex_req_t    head;
	ex_pipe_pkg::ex_req_t    disp_req;
	ex_pipe_pkg::ex_result_t alu_res;
	ex_pipe_pkg::ex_result_t br_res;
	ex_pipe_pkg::ex_result_t rec_d;
	ex_pipe_pkg::ex_result_t rec_q;
	ex_pipe_pkg::ex_result_t res_d;
	ex_pipe_pkg::mul_res_t   mul_q;
	logic [CREDIT_W-1:0]     credits;
	logic                    dispatch;

	// dispatch only with room downstream
	assign dispatch = head.valid && (credits != '0);

	ex_issue_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_queue (
		.clk      (clk),
		.rst_i    (rst_i),
		.req_i    (req_i),
		.pop_i    (dispatch),
		.head_o   (head),
		.credit_o (credit_o)
	);

	always_comb begin
		disp_req       = head;
		disp_req.valid = dispatch;
	end

	ex_alu u_alu (
		.req_i (disp_req),
		.alu_o (alu_res)
	);

	ex_branch_unit u_branch (
		.req_i (disp_req),
		.br_o  (br_res)
	);

	ex_multiplier u_mul (
		.clk   (clk),
		.rst_i (rst_i),
		.req_i (disp_req),
		.mul_o (mul_q)
	);

	always_ff @(posedge clk) begin
		if (rst_i)
			credits <= CREDIT_W'(OUT_CREDITS);
		else
			credits <= credits + CREDIT_W'(credit_i) - CREDIT_W'(dispatch);
	end

	// units zero everything outside their class
	always_comb begin
		if (dispatch) begin
			rec_d       = ex_pipe_pkg::ex_result_t'(alu_res | br_res);
			rec_d.valid = 1'b1;
			rec_d.wd    = head.wd;
			rec_d.wreg  = head.wreg;
		end else begin
			rec_d = '0;
		end
	end

	always_comb begin
		res_d           = rec_q;
		res_d.wreg_real = rec_q.wreg_real | mul_q.wreg;
		res_d.wdata     = rec_q.wdata |
			({ex_isa_pkg::reg_width{mul_q.wreg}} & mul_q.product[31:0]);
		res_d.wreg_hi   = mul_q.wreg_hi;
		res_d.wdata_hi  = {ex_isa_pkg::reg_width{mul_q.wreg_hi}} & mul_q.product[63:32];
		res_d.wreg_lo   = mul_q.wreg_lo;
		res_d.wdata_lo  = {ex_isa_pkg::reg_width{mul_q.wreg_lo}} & mul_q.product[31:0];
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			rec_q <= '0;
			res_o <= '0;
		end else begin
			rec_q <= rec_d;
			res_o <= res_d;
		end
	end

	// consumer never returns more credits than it was given
	a_credit_bound: assert property (@(posedge clk) disable iff (rst_i)
		credits <= CREDIT_W'(OUT_CREDITS));

	// each result still in the pipeline holds one spent credit
	a_no_dry_dispatch: assert property (@(posedge clk) disable iff (rst_i)
		int'(credits) + int'(rec_q.valid) + int'(res_o.valid) <= OUT_CREDITS);

endmodule

//--- sim/ex_testdata.hex
// request fields aluop alusel reg1 reg2 wd wreg pc offset
// then expected wreg_real wdata wreg_hi wdata_hi wreg_lo wdata_lo redirect pc_target excepttype
25 1 f0f00000 0000ff00 01 1 0 0    1 f0f0ff00 0 0 0 0 0 0 0
27 1 00ff00ff 0f000000 02 1 0 0    1 f000ff00 0 0 0 0 0 0 0
5c 1 0 0000abcd 03 1 0 0    1 abcd0000 0 0 0 0 0 0 0
7c 2 00000004 000000f1 04 1 0 0    1 00000f10 0 0 0 0 0 0 0
07 2 00000008 80000000 05 1 0 0    1 ff800000 0 0 0 0 0 0 0
b0 3 00010000 0 06 1 0 0    1 0000000f 0 0 0 0 0 0 0
b1 3 fff00000 0 07 1 0 0    1 0000000c 0 0 0 0 0 0 0
2a 3 ffffffff 00000001 08 1 0 0    1 00000001 0 0 0 0 0 0 0
57 3 fffffff0 0000fff8 09 1 0 0    1 00000001 0 0 0 0 0 0 0
58 3 00000005 0000ffff 0a 1 0 0    1 00000001 0 0 0 0 0 0 0
20 3 7fffffff 00000001 0b 1 0 0    0 80000000 0 0 0 0 0 0 0
21 3 7fffffff 00000001 0c 1 0 0    1 80000000 0 0 0 0 0 0 0
22 3 80000000 00000001 0d 1 0 0    0 7fffffff 0 0 0 0 0 0 0
55 3 00000010 0000fff0 0e 1 0 0    1 0 0 0 0 0 0 0 0
00 0 12345678 9abcdef0 0f 1 0 0    0 0 0 0 0 0 0 0 0
a9 4 fffffffd 00000007 10 1 0 0    1 ffffffeb 0 0 0 0 0 0 0
18 4 fffffffe 00000003 00 0 0 0    0 0 1 ffffffff 1 fffffffa 0 0 0
19 4 ffffffff 00000002 00 0 0 0    0 0 1 00000001 1 fffffffe 0 0 0
50 5 00100000 0 1f 1 80000100 0    1 80000104 0 0 0 0 1 80400000 0
08 5 00400020 0 00 0 00001000 0    0 00001004 0 0 0 0 1 00400020 0
51 6 00000005 00000005 00 0 00002000 fffe    0 00002004 0 0 0 0 1 00001ff8 0
52 6 00000005 00000005 00 0 00003000 0010    0 00003004 0 0 0 0 0 00003040 0
4a 6 80000000 0 1f 1 00004000 0004    1 00004004 0 0 0 0 1 00004010 0
34 0 00000007 00000007 00 0 0 0    0 0 0 0 0 0 0 0 0000000d
36 0 00000003 00000004 00 0 0 0    0 0 0 0 0 0 0 0 0000000d
0c 0 0 0 00 0 0 0    0 0 0 0 0 0 0 0 00000008
6b 0 0 0 00 0 0 0    0 0 0 0 0 0 0 0 0000000e

//--- sim/tb_ex_stage.sv
`timescale 1ns/1ns

module tb_ex_stage;

	localparam int QUEUE_DEPTH = 4;
	localparam int OUT_CREDITS = 2;
	localparam int VEC_WORDS   = 17;
	localparam int MAX_VECS    = 64;
	localparam int TIMEOUT     = 2000;
	localparam int DRAIN       = 8;

	logic                    clk;
	logic                    rst_i;
	ex_pipe_pkg::ex_req_t    req;
	logic                    credit_o;
	ex_pipe_pkg::ex_result_t res;
	logic                    credit_i;

	// one vector is VEC_WORDS words, request fields first
	logic [31:0] vec_mem [MAX_VECS*VEC_WORDS];
	logic [31:0] lfsr;
	int          num_vecs;
	int          issued;
	int          received;
	int          owed;
	int          credits_given;
	int          credits_back;
	int          errors;
	int          cycles;

	ex_stage DUT (
		.clk      (clk),
		.rst_i    (rst_i),
		.req_i    (req),
		.credit_o (credit_o),
		.res_o    (res),
		.credit_i (credit_i)
	);

	always #20 clk = ~clk;

	// galois form, maximal length taps
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_random_bit(output logic b);
		b    = lfsr[0];
		lfsr = lfsr_next(lfsr);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	function automatic ex_pipe_pkg::ex_req_t make_req(input int idx);
		ex_pipe_pkg::ex_req_t r;
		int                   b;
		b        = idx * VEC_WORDS;
		r        = '0;
		r.valid  = 1'b1;
		r.aluop  = ex_isa_pkg::aluop_t'(vec_mem[b][7:0]);
		r.alusel = ex_isa_pkg::alusel_t'(vec_mem[b+1][2:0]);
		r.reg1   = vec_mem[b+2];
		r.reg2   = vec_mem[b+3];
		r.wd     = vec_mem[b+4][4:0];
		r.wreg   = vec_mem[b+5][0];
		r.pc     = vec_mem[b+6];
		r.offset = vec_mem[b+7][15:0];
		return r;
	endfunction

	task automatic compare_result(input int idx);
		int    b;
		string tag;
		b   = idx * VEC_WORDS;
		tag = $sformatf("vector %0d op %02h", idx, vec_mem[b][7:0]);
		check_value({tag, " wd"}, vec_mem[b+4], 32'(res.wd));
		check_value({tag, " wreg"}, vec_mem[b+5], 32'(res.wreg));
		check_value({tag, " wreg_real"}, vec_mem[b+8], 32'(res.wreg_real));
		check_value({tag, " wdata"}, vec_mem[b+9], res.wdata);
		check_value({tag, " wreg_hi"}, vec_mem[b+10], 32'(res.wreg_hi));
		check_value({tag, " wdata_hi"}, vec_mem[b+11], res.wdata_hi);
		check_value({tag, " wreg_lo"}, vec_mem[b+12], 32'(res.wreg_lo));
		check_value({tag, " wdata_lo"}, vec_mem[b+13], res.wdata_lo);
		check_value({tag, " redirect"}, vec_mem[b+14], 32'(res.redirect));
		check_value({tag, " pc_target"}, vec_mem[b+15], res.pc_target);
		check_value({tag, " excepttype"}, vec_mem[b+16], 32'(res.excepttype));
	endtask

	// outputs are flops, so at the edge they still hold last cycle's value
	task automatic sample_outputs();
		if (credit_o)
			credits_back++;
		if (res.valid) begin
			if (received >= num_vecs) begin
				$display("unexpected result for register %0d after the last vector", res.wd);
				errors++;
			end else begin
				if (received >= OUT_CREDITS + credits_given) begin
					$display("result %0d came out before a downstream credit was returned",
						received);
					errors++;
				end
				compare_result(received);
				received++;
				owed++;
			end
		end
	endtask

	task automatic drive_inputs();
		logic issue_bit;
		logic ret_a;
		logic ret_b;
		take_random_bit(issue_bit);
		if (issued < num_vecs && (issued - credits_back) < QUEUE_DEPTH && issue_bit) begin
			req <= make_req(issued);
			issued++;
		end else begin
			req <= '0;
		end
		// credits come back at a quarter rate to build back-pressure
		take_random_bit(ret_a);
		take_random_bit(ret_b);
		if (owed > 0 && ret_a && ret_b) begin
			credit_i <= 1'b1;
			owed--;
			credits_given++;
		end else begin
			credit_i <= 1'b0;
		end
	endtask

	initial begin
		clk           = 1'b0;
		rst_i         = 1'b1;
		req           = '0;
		credit_i      = 1'b0;
		lfsr          = 32'h72f3;
		issued        = 0;
		received      = 0;
		owed          = 0;
		credits_given = 0;
		credits_back  = 0;
		errors        = 0;
		// unread words keep their address-based fill
		for (int i = 0; i < MAX_VECS * VEC_WORDS; i++)
			vec_mem[i] = ~32'(i);
		$readmemh("sim/ex_testdata.hex", vec_mem);
		num_vecs = 0;
		while (num_vecs < MAX_VECS &&
			vec_mem[num_vecs*VEC_WORDS] !== ~32'(num_vecs*VEC_WORDS))
			num_vecs++;
		if (num_vecs == 0) begin
			$display("no test vectors could be read from sim/ex_testdata.hex");
			errors++;
		end

		repeat (3) @(posedge clk);
		rst_i <= 1'b0;

		cycles = 0;
		while (received < num_vecs && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
			sample_outputs();
			drive_inputs();
		end
		if (received < num_vecs) begin
			$display("timeout after %0d cycles, only %0d of %0d results arrived",
				cycles, received, num_vecs);
			errors++;
		end

		// nothing more may come out once the pipeline is empty
		cycles = 0;
		while (cycles < DRAIN) begin
			@(posedge clk);
			cycles++;
			sample_outputs();
			req      <= '0;
			credit_i <= 1'b0;
		end
		check_value("credit_o pulse count", 32'(issued), 32'(credits_back));

		$display("issued %0d, results %0d of %0d, credit pulses %0d, errors %0d",
			issued, received, num_vecs, credits_back, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
